// File: include/precision_consts.svh
`ifndef PRECISION_CONSTS_SVH
`define PRECISION_CONSTS_SVH

// Datapath geometry.
`define LANES                  8
`define LANE_W                 64
`define LOG_ALLOWED_PRECISIONS 2

// Precision codes.
`define INT8  2'd0
`define INT16 2'd1
`define INT32 2'd2
`define INT64 2'd3

`define AXIL_AW 8
`define AXIL_DW 32

`define REG_CTRL   8'h00
`define REG_STATUS 8'h04
`define REG_A_BASE 8'h40
`define REG_B_BASE 8'h80
`define REG_R_BASE 8'hC0

`endif

// File: src/simd_pkg.sv
`include "precision_consts.svh"

package simd_pkg;

  // One lane word seen at every element width, element 0 in the low bits.
  typedef union packed {
    logic [`LANE_W/8-1:0][7:0]   i8;
    logic [`LANE_W/16-1:0][15:0] i16;
    logic [`LANE_W/32-1:0][31:0] i32;
    logic [`LANE_W/64-1:0][63:0] i64;
  } lane_word_u;

  typedef lane_word_u [`LANES-1:0] lane_vec_t;  // Lane 0 in the low bits.

  typedef struct packed {
    lane_vec_t                          a;
    lane_vec_t                          b;
    logic [`LOG_ALLOWED_PRECISIONS-1:0] prec;
  } dot_cmd_t;

  typedef struct packed {
    lane_vec_t result;
    logic      valid;
  } dot_rsp_t;

  typedef struct packed {
    logic [`AXIL_AW-1:0] awaddr;
    logic                awvalid;
    logic [`AXIL_DW-1:0] wdata;
    logic                wvalid;
    logic                bready;
    logic [`AXIL_AW-1:0] araddr;
    logic                arvalid;
    logic                rready;
  } axil_req_t;

  typedef struct packed {
    logic                awready;
    logic                wready;
    logic                bvalid;
    logic [1:0]          bresp;
    logic                arready;
    logic                rvalid;
    logic [`AXIL_DW-1:0] rdata;
    logic [1:0]          rresp;
  } axil_rsp_t;

endpackage

// File: src/lane_dot.sv
`timescale 1ns/10ps

`include "precision_consts.svh"

module lane_dot (
  input  logic                               clk,
  input  logic                               arst_n,
  input  simd_pkg::lane_word_u               a,
  input  simd_pkg::lane_word_u               b,
  input  logic [`LOG_ALLOWED_PRECISIONS-1:0] prec,
  input  logic                               en,
  output simd_pkg::lane_word_u               sum
);

  logic [7:0]           s8;
  logic [15:0]          s16;
  logic [31:0]          s32;
  logic [63:0]          s64;
  simd_pkg::lane_word_u sum_d;

  // Sums are sized to the element, so the adds wrap by themselves.
  always_comb begin
    s8  = '0;
    s16 = '0;
    s32 = '0;
    for (int i = 0; i < `LANE_W / 8; i++)
      s8 = s8 + a.i8[i] * b.i8[i];
    for (int i = 0; i < `LANE_W / 16; i++)
      s16 = s16 + a.i16[i] * b.i16[i];
    for (int i = 0; i < `LANE_W / 32; i++)
      s32 = s32 + a.i32[i] * b.i32[i];
    s64 = a.i64[0] * b.i64[0];
  end

  always_comb begin
    case (prec)
      `INT8:   sum_d.i64[0] = 64'(s8);
      `INT16:  sum_d.i64[0] = 64'(s16);
      `INT32:  sum_d.i64[0] = 64'(s32);
      default: sum_d.i64[0] = s64;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum <= '0;
    end else if (en) begin
      sum <= sum_d;
    end
  end

endmodule

// File: src/compact_and_select.sv
`timescale 1ns/10ps

`include "precision_consts.svh"

module compact_and_select (
  input  simd_pkg::lane_vec_t                data_in,
  input  logic [`LOG_ALLOWED_PRECISIONS-1:0] prec,
  output wire simd_pkg::lane_vec_t           data_out
);

  localparam int EL32 = `LANE_W / 32;
  localparam int EL16 = `LANE_W / 16;
  localparam int EL8  = `LANE_W / 8;

  wire simd_pkg::lane_vec_t d32;
  wire simd_pkg::lane_vec_t d16;
  wire simd_pkg::lane_vec_t d8;

  genvar w, s;
  generate
    for (w = 0; w < `LANES; w++) begin : g_p64
      assign data_out[w] = (prec == `INT64) ? data_in[w] : d32[w];
    end

    // Word w takes lanes w*EL .. w*EL+EL-1; missing lanes give zero.
    for (w = 0; w < `LANES; w++) begin : g_p32
      wire simd_pkg::lane_word_u pk;
      for (s = 0; s < EL32; s++) begin : g_el
        if (w * EL32 + s < `LANES) begin : g_src
          assign pk.i32[s] = data_in[w * EL32 + s].i32[0];
        end else begin : g_zero
          assign pk.i32[s] = '0;
        end
      end
      assign d32[w] = (prec == `INT32) ? pk : d16[w];
    end

    for (w = 0; w < `LANES; w++) begin : g_p16
      wire simd_pkg::lane_word_u pk;
      for (s = 0; s < EL16; s++) begin : g_el
        if (w * EL16 + s < `LANES) begin : g_src
          assign pk.i16[s] = data_in[w * EL16 + s].i16[0];
        end else begin : g_zero
          assign pk.i16[s] = '0;
        end
      end
      assign d16[w] = (prec == `INT16) ? pk : d8[w];
    end

    for (w = 0; w < `LANES; w++) begin : g_p8
      wire simd_pkg::lane_word_u pk;
      for (s = 0; s < EL8; s++) begin : g_el
        if (w * EL8 + s < `LANES) begin : g_src
          assign pk.i8[s] = data_in[w * EL8 + s].i8[0];
        end else begin : g_zero
          assign pk.i8[s] = '0;
        end
      end
      assign d8[w] = (prec == `INT8) ? pk : '0;  // End of the cascade.
    end
  endgenerate

endmodule

// File: src/dot_engine.sv
`timescale 1ns/10ps

`include "precision_consts.svh"

module dot_engine (
  input  logic               clk,
  input  logic               arst_n,
  input  simd_pkg::dot_cmd_t cmd,
  input  logic               start,
  output simd_pkg::dot_rsp_t rsp
);

  wire simd_pkg::lane_vec_t           lane_sum;
  wire simd_pkg::lane_vec_t           packed_res;
  logic [`LOG_ALLOWED_PRECISIONS-1:0] prec_q;
  logic                               vld_q;

  genvar l;
  generate
    for (l = 0; l < `LANES; l++) begin : g_lane
      lane_dot u_lane (
        .clk    (clk),
        .arst_n (arst_n),
        .a      (cmd.a[l]),
        .b      (cmd.b[l]),
        .prec   (cmd.prec),
        .en     (start),
        .sum    (lane_sum[l])
      );
    end
  endgenerate

  // Stage 1 side band, aligned with the lane registers.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prec_q <= '0;
      vld_q  <= 1'b0;
    end else begin
      vld_q <= start;
      if (start) begin
        prec_q <= cmd.prec;
      end
    end
  end

  compact_and_select u_compact (
    .data_in  (lane_sum),
    .prec     (prec_q),
    .data_out (packed_res)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp <= '0;
    end else begin
      rsp.valid <= vld_q;
      if (vld_q) begin
        rsp.result <= packed_res;  // Stage 2.
      end
    end
  end

endmodule

// File: src/axil_regs.sv
`timescale 1ns/10ps

`include "precision_consts.svh"

module axil_regs (
  input  logic                clk,
  input  logic                arst_n,
  input  simd_pkg::axil_req_t axil_req,
  output simd_pkg::axil_rsp_t axil_rsp,
  output simd_pkg::dot_cmd_t  cmd,
  output logic                start,
  input  simd_pkg::dot_rsp_t  rsp
);

  simd_pkg::lane_vec_t                a_q;
  simd_pkg::lane_vec_t                b_q;
  simd_pkg::lane_vec_t                res_q;
  logic [`LOG_ALLOWED_PRECISIONS-1:0] prec_q;
  logic                               done_q;

  logic                bvalid_q;
  logic                rvalid_q;
  logic [`AXIL_DW-1:0] rdata_q;
  logic [`AXIL_DW-1:0] rd_data;

  logic       wr_hs;
  logic       rd_hs;
  logic [2:0] wr_lane;
  logic       wr_half;
  logic [2:0] rd_lane;
  logic       rd_half;

  // Upper two address bits pick the A, B or result block.
  function automatic logic in_block(input logic [`AXIL_AW-1:0] addr,
                                    input logic [`AXIL_AW-1:0] base);
    return addr[`AXIL_AW-1:6] == base[`AXIL_AW-1:6];
  endfunction

  assign wr_hs   = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;
  assign rd_hs   = axil_req.arvalid & ~rvalid_q;
  assign wr_lane = axil_req.awaddr[5:3];
  assign wr_half = axil_req.awaddr[2];  // Odd word is the high half.
  assign rd_lane = axil_req.araddr[5:3];
  assign rd_half = axil_req.araddr[2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_q    <= '0;
      b_q    <= '0;
      prec_q <= '0;
      start  <= 1'b0;
    end else begin
      start <= 1'b0;
      if (wr_hs) begin
        if (axil_req.awaddr == `REG_CTRL) begin
          prec_q <= axil_req.wdata[`LOG_ALLOWED_PRECISIONS-1:0];
          start  <= axil_req.wdata[8];  // Go bit.
        end else if (in_block(axil_req.awaddr, `REG_A_BASE)) begin
          a_q[wr_lane].i32[wr_half] <= axil_req.wdata;
        end else if (in_block(axil_req.awaddr, `REG_B_BASE)) begin
          b_q[wr_lane].i32[wr_half] <= axil_req.wdata;
        end
      end
    end
  end

  // A new start takes priority, so done always refers to the latest command.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_q  <= '0;
      done_q <= 1'b0;
    end else begin
      if (rsp.valid) begin
        res_q <= rsp.result;
      end
      if (start) begin
        done_q <= 1'b0;
      end else if (rsp.valid) begin
        done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    rd_data = '0;
    if (axil_req.araddr == `REG_CTRL) begin
      rd_data[`LOG_ALLOWED_PRECISIONS-1:0] = prec_q;
    end else if (axil_req.araddr == `REG_STATUS) begin
      rd_data[0] = done_q;
    end else if (in_block(axil_req.araddr, `REG_A_BASE)) begin
      rd_data = a_q[rd_lane].i32[rd_half];
    end else if (in_block(axil_req.araddr, `REG_B_BASE)) begin
      rd_data = b_q[rd_lane].i32[rd_half];
    end else if (in_block(axil_req.araddr, `REG_R_BASE)) begin
      rd_data = res_q[rd_lane].i32[rd_half];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rd_data;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  assign cmd = '{a: a_q, b: b_q, prec: prec_q};

  always_comb begin
    axil_rsp.awready = wr_hs;
    axil_rsp.wready  = wr_hs;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = 2'b00;  // Always OKAY.
    axil_rsp.arready = ~rvalid_q;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = 2'b00;
  end

endmodule

// File: src/simd_dot_top.sv
`timescale 1ns/10ps

module simd_dot_top (
  input  logic                clk,
  input  logic                arst_n,
  input  simd_pkg::axil_req_t axil_req,
  output simd_pkg::axil_rsp_t axil_rsp
);

  simd_pkg::dot_cmd_t cmd;
  simd_pkg::dot_rsp_t rsp;
  logic               start;

  axil_regs u_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .cmd      (cmd),
    .start    (start),
    .rsp      (rsp)
  );

  dot_engine u_engine (
    .clk    (clk),
    .arst_n (arst_n),
    .cmd    (cmd),
    .start  (start),
    .rsp    (rsp)
  );

endmodule

// File: verif/simd_dot_tb.sv
`timescale 1ns/10ps

`include "precision_consts.svh"

module simd_dot_tb;

  localparam int MAX_CYCLES = 30000;  // About 55 ops x 50 transfers x 10 cycles.

  logic                clk;
  logic                arst_n;
  simd_pkg::axil_req_t axil_req;
  simd_pkg::axil_rsp_t axil_rsp;
  logic [511:0]        a_v;
  logic [511:0]        b_v;
  logic [511:0]        res_v;
  int                  cycles;
  int                  errors;
  int                  errs_before;
  int                  n_pass;
  int                  n_fail;
  int                  stall_max;
  string               test_name;

  simd_dot_top DUT (.clk(clk), .arst_n(arst_n), .axil_req(axil_req), .axil_rsp(axil_rsp));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles.", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    logic hs;
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      @(negedge clk);
      hs = axil_rsp.awready;
      if (hs) begin
        check_value(test_name, 32'd1, 32'(axil_rsp.wready));  // Raised with awready.
      end
      step();
    end
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    repeat ($urandom_range(stall_max, 0)) step();  // Hold off bready.
    axil_req.bready = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      @(negedge clk);
      hs = axil_rsp.bvalid;
      if (hs) begin
        check_value(test_name, 32'd0, 32'(axil_rsp.bresp));  // OKAY.
      end
      step();
    end
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    logic hs;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      @(negedge clk);
      hs = axil_rsp.arready;
      step();
    end
    axil_req.arvalid = 1'b0;
    repeat ($urandom_range(stall_max, 0)) step();  // Hold off rready.
    axil_req.rready = 1'b1;
    hs = 1'b0;
    while (!hs) begin
      @(negedge clk);
      hs   = axil_rsp.rvalid;
      data = axil_rsp.rdata;
      if (hs) begin
        check_value(test_name, 32'd0, 32'(axil_rsp.rresp));  // OKAY.
      end
      step();
    end
    axil_req.rready = 1'b0;
  endtask

  // Wrapped lane sums, then lane l packed at element position l.
  function automatic logic [511:0] dot_model(input logic [511:0] a, input logic [511:0] b,
                                             input logic [1:0] prec);
    logic [511:0] res;
    logic [511:0] sa;
    logic [511:0] sb;
    logic [63:0]  mask;
    logic [63:0]  acc;
    int           p;
    res  = '0;
    p    = 8 << prec;
    mask = (p == 64) ? '1 : (64'd1 << p) - 64'd1;
    for (int l = 0; l < 8; l++) begin
      acc = '0;
      for (int e = 0; e < 64 / p; e++) begin
        sa  = a >> (l * 64 + e * p);
        sb  = b >> (l * 64 + e * p);
        acc = acc + (sa[63:0] & mask) * (sb[63:0] & mask);
      end
      acc = acc & mask;
      for (int k = 0; k < p; k++) begin
        res[l * p + k] = acc[k];
      end
    end
    return res;
  endfunction

  task automatic start_test(input string name);
    test_name   = name;
    errs_before = errors;
  endtask

  task automatic end_test();
    if (errors == errs_before) begin
      n_pass++;
      $display("%s: passed", test_name);
    end else begin
      n_fail++;
      $display("%s: failed with %0d errors", test_name, errors - errs_before);
    end
  endtask

  task automatic random_operands();
    for (int j = 0; j < 16; j++) begin
      a_v[j * 32 +: 32] = $urandom;
      b_v[j * 32 +: 32] = $urandom;
    end
  endtask

  task automatic load_operands();
    for (int j = 0; j < 16; j++) begin
      axil_write(8'(`REG_A_BASE + 4 * j), a_v[j * 32 +: 32]);
      axil_write(8'(`REG_B_BASE + 4 * j), b_v[j * 32 +: 32]);
    end
  endtask

  task automatic check_regs();
    logic [31:0] got;
    for (int j = 0; j < 16; j++) begin
      axil_read(8'(`REG_A_BASE + 4 * j), got);
      check_value(test_name, a_v[j * 32 +: 32], got);
      axil_read(8'(`REG_B_BASE + 4 * j), got);
      check_value(test_name, b_v[j * 32 +: 32], got);
    end
  endtask

  task automatic check_results();
    logic [31:0] got;
    for (int j = 0; j < 16; j++) begin
      axil_read(8'(`REG_R_BASE + 4 * j), got);
      check_value(test_name, res_v[j * 32 +: 32], got);
    end
  endtask

  task automatic wait_done();
    logic [31:0] st;
    st = '0;
    while (!st[0]) begin
      axil_read(`REG_STATUS, st);
    end
  endtask

  task automatic run_op(input logic [1:0] prec);
    logic [31:0] got;
    load_operands();
    axil_write(`REG_CTRL, 32'h100 | prec);  // Go bit plus precision.
    wait_done();
    res_v = dot_model(a_v, b_v, prec);
    check_results();
    axil_read(`REG_CTRL, got);
    check_value(test_name, 32'(prec), got);
  endtask

  initial begin
    logic [31:0]  got;
    logic [511:0] sign_v;
    void'($urandom(32'hcdd2_a997));
    axil_req  = '0;
    arst_n    = 1'b0;
    cycles    = 0;
    errors    = 0;
    n_pass    = 0;
    n_fail    = 0;
    stall_max = 3;
    res_v     = '0;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    start_test("reset");
    axil_read(`REG_STATUS, got);
    check_value(test_name, 32'd0, got);
    axil_read(`REG_CTRL, got);
    check_value(test_name, 32'd0, got);
    check_results();
    end_test();

    start_test("regfile");
    random_operands();
    load_operands();
    check_regs();
    for (int j = 0; j < 16; j++) begin
      axil_write(8'(`REG_R_BASE + 4 * j), $urandom);  // Read-only words.
    end
    check_results();
    end_test();

    for (int q = 3; q >= 0; q--) begin
      start_test($sformatf("random_int%0d", 8 << q));
      repeat (10) begin
        random_operands();
        run_op(q);
      end
      end_test();
    end

    start_test("wrap");
    for (int q = 3; q >= 0; q--) begin
      for (int i = 0; i < 512; i++) begin
        sign_v[i] = (i % (8 << q)) == (8 << q) - 1;  // Sign bit of each element.
      end
      a_v = '1;
      b_v = '1;
      run_op(q);
      a_v = sign_v;
      b_v = sign_v;
      run_op(q);
      b_v = '1;
      run_op(q);
    end
    end_test();

    start_test("restart");
    stall_max = 0;
    random_operands();
    load_operands();
    axil_write(`REG_CTRL, 32'h100 | `INT32);
    axil_read(`REG_STATUS, got);
    check_value(test_name, 32'd0, got);
    wait_done();
    res_v = dot_model(a_v, b_v, `INT32);
    check_results();
    axil_write(`REG_CTRL, 32'h100 | `INT16);
    axil_write(`REG_CTRL, 32'h100 | `INT8);
    wait_done();
    res_v = dot_model(a_v, b_v, `INT8);
    check_results();
    end_test();

    start_test("stall");
    stall_max = 8;
    check_regs();
    check_results();
    axil_read(`REG_CTRL, got);
    check_value(test_name, 32'(`INT8), got);
    axil_read(`REG_STATUS, got);
    check_value(test_name, 32'd1, got);
    end_test();

    $display("Tests passed: %0d, tests failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
src/simd_pkg.sv
src/lane_dot.sv
src/compact_and_select.sv
src/dot_engine.sv
src/axil_regs.sv
src/simd_dot_top.sv
verif/simd_dot_tb.sv
